//--- buf_desc_pkg.sv
package buf_desc_pkg;

    // ----------------------------------------------------------------------
    // Buffer geometry
    // ----------------------------------------------------------------------
    parameter int NUM_BUFFERS = 64;
    parameter int PTR_WID     = $clog2(NUM_BUFFERS);
    parameter int BUFFER_SIZE = 256;

    // One extra bit so a completely full buffer fits
    parameter int SIZE_WID = $clog2(BUFFER_SIZE) + 1;

    // ----------------------------------------------------------------------
    // Frame limits and metadata
    // ----------------------------------------------------------------------
    parameter int MAX_FRAME_SIZE = 16384;
    parameter int FRAME_SIZE_WID = $clog2(MAX_FRAME_SIZE + 1);
    parameter int META_WID       = 8;

    // Word held in descriptor memory, one per buffer
    typedef struct packed {
        logic                sof;
        logic                eof;
        logic [PTR_WID-1:0]  nxt_ptr;
        logic [SIZE_WID-1:0] size;
        logic [META_WID-1:0] meta;
        logic                err;
    } desc_t;

endpackage : buf_desc_pkg

//--- scatter_pkg.sv
package scatter_pkg;

    import buf_desc_pkg::*;

    // Context to core
    // nxt_ptr is the buffer this segment lands in, taken beforehand
    typedef struct packed {
        logic                req;
        logic                vld;
        logic                sof;
        logic                eof;
        logic [SIZE_WID-1:0] size;
        logic [PTR_WID-1:0]  nxt_ptr;
        logic [META_WID-1:0] meta;
        logic                err;
    } scatter_req_t;

    // Core to context
    typedef struct packed {
        logic               rdy;
        logic [PTR_WID-1:0] ptr;
        logic               ack;
    } scatter_resp_t;

    // Frame completion, qualified by a per-context valid bit
    typedef struct packed {
        logic                      error;
        logic [PTR_WID-1:0]        ptr;
        logic [FRAME_SIZE_WID-1:0] size;
    } frame_cpl_t;

    typedef enum logic [2:0] {
        RESET,
        DISABLED,
        IDLE,
        WRITE,
        DONE
    } scatter_state_e;

endpackage : scatter_pkg

//--- fifo_ctxt.sv
`timescale 1ns/1ns

module fifo_ctxt #(
    parameter int DATA_WID = 8,
    parameter int DEPTH    = 4
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                wr,
    input  logic [DATA_WID-1:0] wr_data,
    output logic                wr_rdy,
    input  logic                rd,
    output logic                rd_vld,
    output logic [DATA_WID-1:0] rd_data,
    output logic                oflow,
    output logic                uflow
);

    localparam int AW      = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    logic [DATA_WID-1:0] mem [DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [CNT_WID-1:0]  count;
    logic                do_wr;
    logic                do_rd;

    // Wrap at DEPTH so non power of two depths work
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_rdy  = (count < CNT_WID'(DEPTH));
    assign rd_vld  = (count != '0);
    assign rd_data = mem[rd_ptr];
    assign do_wr   = wr && wr_rdy;
    assign do_rd   = rd && rd_vld;
    assign oflow   = wr && !wr_rdy;
    assign uflow   = rd && !rd_vld;

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CNT_WID'(do_wr) - CNT_WID'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

    // Callers must respect the flags
    assert property (@(posedge clk) disable iff (srst) wr |-> wr_rdy)
        else $error("fifo_ctxt: write while full");
    assert property (@(posedge clk) disable iff (srst) rd |-> rd_vld)
        else $error("fifo_ctxt: read while empty");

endmodule : fifo_ctxt

//--- arb_rr.sv
`timescale 1ns/1ns

module arb_rr #(
    parameter int N = 2
) (
    input  logic                                  clk,
    input  logic                                  srst,
    input  logic                                  en,
    input  logic [N-1:0]                          req,
    output logic [((N > 1) ? $clog2(N) : 1)-1:0] sel
);

    localparam int SEL_WID = (N > 1) ? $clog2(N) : 1;

    logic [SEL_WID-1:0] last;

    // Search starts one past the last grant and wraps
    always_comb begin
        int   idx;
        logic found;
        sel   = last;
        found = 1'b0;
        for (int i = 1; i <= N; i++) begin
            idx = (int'(last) + i) % N;
            if (!found && req[idx]) begin
                sel   = SEL_WID'(idx);
                found = 1'b1;
            end
        end
    end

    // Start at N-1 so index 0 wins first
    always_ff @(posedge clk) begin
        if (srst) begin
            last <= SEL_WID'(N - 1);
        end else if (en) begin
            last <= sel;
        end
    end

endmodule : arb_rr

//--- buf_free_list.sv
`timescale 1ns/1ns

module buf_free_list
    import buf_desc_pkg::*;
(
    input  logic               clk,
    input  logic               srst,
    input  logic               alloc_req,
    output logic               alloc_rdy,
    output logic [PTR_WID-1:0] alloc_ptr,
    input  logic               free_vld,
    input  logic [PTR_WID-1:0] free_ptr
);

    logic [PTR_WID-1:0] fill_cnt;
    logic               fill_done;
    logic               fifo_wr;
    logic [PTR_WID-1:0] fifo_wr_data;
    logic               fifo_wr_rdy;
    logic               fifo_rd_vld;

    // ----------------------------------------------------------------------
    // Fill pass, one pointer per cycle
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            fill_cnt  <= '0;
            fill_done <= 1'b0;
        end else if (!fill_done) begin
            fill_cnt <= fill_cnt + 1'b1;
            if (fill_cnt == PTR_WID'(NUM_BUFFERS - 1)) fill_done <= 1'b1;
        end
    end

    assign fifo_wr      = !fill_done || free_vld;
    assign fifo_wr_data = fill_done ? free_ptr : fill_cnt;

    // Pool only offered once every pointer is in
    assign alloc_rdy = fill_done && fifo_rd_vld;

    fifo_ctxt #(
        .DATA_WID ( PTR_WID ),
        .DEPTH    ( NUM_BUFFERS )
    ) i_fifo_ctxt__pool (
        .clk,
        .srst,
        .wr      ( fifo_wr ),
        .wr_data ( fifo_wr_data ),
        .wr_rdy  ( fifo_wr_rdy ),
        .rd      ( alloc_req && alloc_rdy ),
        .rd_vld  ( fifo_rd_vld ),
        .rd_data ( alloc_ptr ),
        .oflow   ( ),
        .uflow   ( )
    );

    // A free into a full pool means a pointer was returned twice
    assert property (@(posedge clk) disable iff (srst)
        free_vld |-> (fill_done && fifo_wr_rdy))
        else $error("buf_free_list: free with pool full or still filling");

endmodule : buf_free_list

//--- desc_mem.sv
`timescale 1ns/1ns

module desc_mem
    import buf_desc_pkg::*;
(
    input  logic               clk,
    input  logic               srst,
    output logic               init_done,
    input  logic               wr_req,
    output logic               wr_rdy,
    input  logic [PTR_WID-1:0] wr_addr,
    input  desc_t              wr_data,
    input  logic [PTR_WID-1:0] rd_addr,
    output desc_t              rd_data
);

    desc_t              mem [NUM_BUFFERS];
    logic [PTR_WID-1:0] clr_cnt;

    // ----------------------------------------------------------------------
    // Clear pass after reset
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            clr_cnt   <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            clr_cnt <= clr_cnt + 1'b1;
            if (clr_cnt == PTR_WID'(NUM_BUFFERS - 1)) init_done <= 1'b1;
        end
    end

    assign wr_rdy = init_done;

    // Clear pass owns the write port until done
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[clr_cnt] <= '0;
        end else if (wr_req) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule : desc_mem

//--- alloc_scatter_core.sv
`timescale 1ns/1ns

module alloc_scatter_core
    import buf_desc_pkg::*;
    import scatter_pkg::*;
#(
    parameter int CONTEXTS = 2,
    parameter int Q_DEPTH  = 4
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                en,
    input  scatter_req_t        scatter_req [CONTEXTS],
    output scatter_resp_t       scatter_resp [CONTEXTS],
    output logic [CONTEXTS-1:0] frame_valid,
    output frame_cpl_t          frame_cpl,
    output logic                alloc_req,
    input  logic                alloc_rdy,
    input  logic [PTR_WID-1:0]  alloc_ptr,
    output logic                wr_req,
    input  logic                wr_rdy,
    output logic [PTR_WID-1:0]  wr_addr,
    output desc_t               wr_data,
    input  logic                init_done
);

    localparam int CTXT_WID = (CONTEXTS > 1) ? $clog2(CONTEXTS) : 1;

    // Queued segment, ptr is the buffer it is stored in
    typedef struct packed {
        logic                sof;
        logic                eof;
        logic [SIZE_WID-1:0] size;
        logic [PTR_WID-1:0]  ptr;
        logic [META_WID-1:0] meta;
        logic                err;
    } req_ctxt_t;

    scatter_state_e      state;
    scatter_state_e      nxt_state;
    logic [CTXT_WID-1:0] alloc_sel;
    logic [CTXT_WID-1:0] ctxt_sel;
    logic [CTXT_WID-1:0] ctxt_sel_r;
    logic [CONTEXTS-1:0] alloc_q_wr_rdy;
    logic [CONTEXTS-1:0] desc_valid;
    logic [PTR_WID-1:0]  desc_ptr [CONTEXTS];
    desc_t               desc_arr [CONTEXTS];
    frame_cpl_t          cpl_arr [CONTEXTS];
    logic                arb;
    logic                wr_done;
    logic [PTR_WID-1:0]  addr_r;
    desc_t               desc_r;

    // ----------------------------------------------------------------------
    // Pointer prefetch, offered to each context in turn
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            alloc_sel <= '0;
        end else if (alloc_sel == CTXT_WID'(CONTEXTS - 1)) begin
            alloc_sel <= '0;
        end else begin
            alloc_sel <= alloc_sel + 1'b1;
        end
    end

    assign alloc_req = (state != RESET) && alloc_q_wr_rdy[alloc_sel];
    assign wr_done   = wr_req && wr_rdy;

    for (genvar g = 0; g < CONTEXTS; g++) begin : g_ctxt
        logic                      ptr_vld;
        logic [PTR_WID-1:0]        ptr_head;
        logic                      ack;
        logic                      req_q_wr_rdy;
        logic                      req_q_rd;
        logic                      nxt_vld;
        logic                      head_vld;
        logic                      seg_done;
        logic [FRAME_SIZE_WID-1:0] seg_size;
        logic [PTR_WID-1:0]        ptr_acc;
        logic [FRAME_SIZE_WID-1:0] size_acc;
        logic                      err_acc;
        req_ctxt_t                 req_in;
        req_ctxt_t                 nxt;
        req_ctxt_t                 head;

        fifo_ctxt #(
            .DATA_WID ( PTR_WID ),
            .DEPTH    ( Q_DEPTH )
        ) i_fifo_ctxt__ptr_q (
            .clk,
            .srst,
            .wr      ( (alloc_sel == CTXT_WID'(g)) && alloc_req && alloc_rdy ),
            .wr_data ( alloc_ptr ),
            .wr_rdy  ( alloc_q_wr_rdy[g] ),
            .rd      ( scatter_req[g].req ),
            .rd_vld  ( ptr_vld ),
            .rd_data ( ptr_head ),
            .oflow   ( ),
            .uflow   ( )
        );

        // Nothing accepted before the memory is cleared
        assign ack = req_q_wr_rdy && (state != RESET);
        assign scatter_resp[g] = '{rdy: ptr_vld, ptr: ptr_head, ack: ack};

        assign req_in = '{
            sof:  scatter_req[g].sof,
            eof:  scatter_req[g].eof,
            size: scatter_req[g].size,
            ptr:  scatter_req[g].nxt_ptr,
            meta: scatter_req[g].meta,
            err:  scatter_req[g].err
        };

        fifo_ctxt #(
            .DATA_WID ( $bits(req_ctxt_t) ),
            .DEPTH    ( Q_DEPTH )
        ) i_fifo_ctxt__req_q (
            .clk,
            .srst,
            .wr      ( scatter_req[g].vld && ack ),
            .wr_data ( req_in ),
            .wr_rdy  ( req_q_wr_rdy ),
            .rd      ( req_q_rd ),
            .rd_vld  ( nxt_vld ),
            .rd_data ( nxt ),
            .oflow   ( ),
            .uflow   ( )
        );

        // Head register, so the successor pointer is visible at the FIFO output
        assign seg_done = wr_done && (ctxt_sel_r == CTXT_WID'(g));
        assign req_q_rd = (!head_vld || seg_done) && nxt_vld;

        always_ff @(posedge clk) begin
            if (srst) begin
                head_vld <= 1'b0;
            end else if (!head_vld || seg_done) begin
                head_vld <= nxt_vld;
            end
        end

        always_ff @(posedge clk) begin
            if (req_q_rd) head <= nxt;
        end

        // Final segment counts its own size, others a full buffer
        assign seg_size = head.eof ? FRAME_SIZE_WID'(head.size) : FRAME_SIZE_WID'(BUFFER_SIZE);

        always_ff @(posedge clk) begin
            if (seg_done) begin
                if (head.sof) begin
                    ptr_acc  <= head.ptr;
                    size_acc <= seg_size;
                    err_acc  <= head.err;
                end else begin
                    size_acc <= size_acc + seg_size;
                    err_acc  <= err_acc | head.err;
                end
            end
        end

        assign cpl_arr[g]    = '{error: err_acc, ptr: ptr_acc, size: size_acc};
        assign desc_valid[g] = head_vld && (head.eof || nxt_vld);
        assign desc_ptr[g]   = head.ptr;
        assign desc_arr[g]   = '{
            sof:     head.sof,
            eof:     head.eof,
            nxt_ptr: nxt.ptr,
            size:    head.size,
            meta:    head.meta,
            err:     head.err
        };
    end : g_ctxt

    // ----------------------------------------------------------------------
    // Descriptor write FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            RESET: begin
                if (init_done) nxt_state = en ? IDLE : DISABLED;
            end
            DISABLED: begin
                if (en) nxt_state = IDLE;
            end
            IDLE: begin
                if (!en) begin
                    nxt_state = DISABLED;
                end else if (|desc_valid) begin
                    nxt_state = WRITE;
                end
            end
            WRITE: begin
                if (wr_rdy) nxt_state = desc_r.eof ? DONE : IDLE;
            end
            DONE: begin
                nxt_state = IDLE;
            end
            default: begin
                nxt_state = RESET;
            end
        endcase
    end

    assign arb = (state == IDLE) && en && (|desc_valid);

    arb_rr #(
        .N ( CONTEXTS )
    ) i_arb_rr__ctxt (
        .clk,
        .srst,
        .en  ( arb ),
        .req ( desc_valid ),
        .sel ( ctxt_sel )
    );

    // Winner held steady for the whole write
    always_ff @(posedge clk) begin
        if (arb) begin
            ctxt_sel_r <= ctxt_sel;
            addr_r     <= desc_ptr[ctxt_sel];
            desc_r     <= desc_arr[ctxt_sel];
        end
    end

    assign wr_req  = (state == WRITE);
    assign wr_addr = addr_r;
    assign wr_data = desc_r;

    always_comb begin
        for (int i = 0; i < CONTEXTS; i++) begin
            frame_valid[i] = (state == DONE) && (ctxt_sel_r == CTXT_WID'(i));
        end
    end

    assign frame_cpl = cpl_arr[ctxt_sel_r];

    // A stalled write holds its address and stays in WRITE
    assert property (@(posedge clk) disable iff (srst)
        (state == WRITE && !wr_rdy) |=> (state == WRITE && $stable(wr_addr)))
        else $error("alloc_scatter_core: write address moved while stalled");

    assert property (@(posedge clk) disable iff (srst) $onehot0(frame_valid))
        else $error("alloc_scatter_core: more than one frame_valid bit set");

endmodule : alloc_scatter_core

//--- scatter_top.sv
`timescale 1ns/1ns

module scatter_top
    import buf_desc_pkg::*;
    import scatter_pkg::*;
#(
    parameter int CONTEXTS = 2,
    parameter int Q_DEPTH  = 4
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                en,
    input  scatter_req_t        scatter_req [CONTEXTS],
    output scatter_resp_t       scatter_resp [CONTEXTS],
    output logic [CONTEXTS-1:0] frame_valid,
    output frame_cpl_t          frame_cpl,
    input  logic                free_vld,
    input  logic [PTR_WID-1:0]  free_ptr,
    input  logic [PTR_WID-1:0]  desc_rd_addr,
    output desc_t               desc_rd_data
);

    logic               alloc_req;
    logic               alloc_rdy;
    logic [PTR_WID-1:0] alloc_ptr;
    logic               wr_req;
    logic               wr_rdy;
    logic [PTR_WID-1:0] wr_addr;
    desc_t              wr_data;
    logic               init_done;

    buf_free_list i_buf_free_list (
        .clk,
        .srst,
        .alloc_req,
        .alloc_rdy,
        .alloc_ptr,
        .free_vld,
        .free_ptr
    );

    alloc_scatter_core #(
        .CONTEXTS ( CONTEXTS ),
        .Q_DEPTH  ( Q_DEPTH )
    ) i_alloc_scatter_core (
        .clk,
        .srst,
        .en,
        .scatter_req,
        .scatter_resp,
        .frame_valid,
        .frame_cpl,
        .alloc_req,
        .alloc_rdy,
        .alloc_ptr,
        .wr_req,
        .wr_rdy,
        .wr_addr,
        .wr_data,
        .init_done
    );

    desc_mem i_desc_mem (
        .clk,
        .srst,
        .init_done,
        .wr_req,
        .wr_rdy,
        .wr_addr,
        .wr_data,
        .rd_addr ( desc_rd_addr ),
        .rd_data ( desc_rd_data )
    );

endmodule : scatter_top

//--- tb_scatter.sv
`timescale 1ns/1ns

module tb_scatter
    import buf_desc_pkg::*;
    import scatter_pkg::*;
();

    localparam int CONTEXTS = 2;
    localparam int MAX_SEGS = 16;
    localparam int TMO      = 2000;

    typedef struct packed {
        int ctx;
        int segs;
        int last;
        int meta;
        int err_seg;
    } frame_t;

    // Buffer taken for one segment and the descriptor it should hold
    typedef struct packed {
        logic [PTR_WID-1:0] ptr;
        desc_t              exp;
    } seg_rec_t;

    logic                clk;
    logic                srst;
    logic                en;
    scatter_req_t        scatter_req [CONTEXTS];
    scatter_resp_t       scatter_resp [CONTEXTS];
    logic [CONTEXTS-1:0] frame_valid;
    frame_cpl_t          frame_cpl;
    logic                free_vld;
    logic [PTR_WID-1:0]  free_ptr;
    logic [PTR_WID-1:0]  desc_rd_addr;
    desc_t               desc_rd_data;

    frame_t             frames [$];
    seg_rec_t           chk_q [$];
    logic [PTR_WID-1:0] took [CONTEXTS][MAX_SEGS];
    logic               outstanding [NUM_BUFFERS];
    int                 workers_done;
    int                 total_bufs;

    scatter_top #(
        .CONTEXTS ( CONTEXTS ),
        .Q_DEPTH  ( 4 )
    ) i_dut (
        .clk,
        .srst,
        .en,
        .scatter_req,
        .scatter_resp,
        .frame_valid,
        .frame_cpl,
        .free_vld,
        .free_ptr,
        .desc_rd_addr,
        .desc_rd_data
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Helpers that start and end 2 ns after a rising edge
    // ----------------------------------------------------------------------
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (exp !== act) begin
            abort_run($sformatf("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act));
        end
    endtask

    // Descriptor that segment s of a frame should leave in memory
    function automatic desc_t expect_desc(input int c, input frame_t f, input int s);
        desc_t d;
        d.sof     = (s == 0);
        d.eof     = (s == f.segs - 1);
        d.nxt_ptr = d.eof ? '0 : took[c][s+1];
        d.size    = d.eof ? SIZE_WID'(f.last) : SIZE_WID'(BUFFER_SIZE);
        d.meta    = META_WID'(f.meta);
        d.err     = (s == f.err_seg);
        return d;
    endfunction

    task automatic take_ptr(input int c, output logic [PTR_WID-1:0] p);
        int n;
        n = 0;
        while (!scatter_resp[c].rdy) begin
            if (n == TMO) abort_run($sformatf("Timeout waiting for a pointer on context %0d", c));
            tick();
            n++;
        end
        p = scatter_resp[c].ptr;
        check_val($sformatf("ctx%0d pointer %0d unique", c, p), 0, 32'(outstanding[p]));
        outstanding[p] = 1'b1;
        total_bufs++;
        scatter_req[c].req = 1'b1;
        tick();
        scatter_req[c].req = 1'b0;
    endtask

    task automatic post_seg(input int c, input frame_t f, input int s);
        desc_t d;
        int    n;
        d = expect_desc(c, f, s);
        scatter_req[c].vld     = 1'b1;
        scatter_req[c].sof     = d.sof;
        scatter_req[c].eof     = d.eof;
        scatter_req[c].size    = d.size;
        scatter_req[c].nxt_ptr = took[c][s];
        scatter_req[c].meta    = d.meta;
        scatter_req[c].err     = d.err;
        n = 0;
        while (!scatter_resp[c].ack) begin
            if (n == TMO) abort_run($sformatf("Timeout waiting for ack on context %0d", c));
            tick();
            n++;
        end
        tick();
        scatter_req[c].vld = 1'b0;
    endtask

    task automatic post_frame(input int c, input frame_t f);
        int gap;
        for (int s = 0; s < f.segs; s++) begin
            take_ptr(c, took[c][s]);
            post_seg(c, f, s);
            gap = int'($urandom % 3);
            repeat (gap) tick();
        end
    endtask

    task automatic finish_frame(input int c, input frame_t f);
        seg_rec_t r;
        int       n;
        n = 0;
        while (!frame_valid[c]) begin
            if (n == TMO) abort_run($sformatf("Timeout waiting for frame_valid on context %0d", c));
            tick();
            n++;
        end
        check_val($sformatf("ctx%0d frame ptr", c), 32'(took[c][0]), 32'(frame_cpl.ptr));
        check_val($sformatf("ctx%0d frame size", c), (f.segs - 1) * BUFFER_SIZE + f.last,
                  32'(frame_cpl.size));
        check_val($sformatf("ctx%0d frame error", c), 32'(f.err_seg >= 0),
                  32'(frame_cpl.error));
        // Hand the buffers over to the chain checker
        for (int s = 0; s < f.segs; s++) begin
            r.ptr = took[c][s];
            r.exp = expect_desc(c, f, s);
            chk_q.push_back(r);
        end
        tick();
    endtask

    task automatic run_context(input int c);
        for (int i = 1; i < frames.size(); i++) begin
            if (frames[i].ctx == c) begin
                post_frame(c, frames[i]);
                finish_frame(c, frames[i]);
            end
        end
        workers_done++;
    endtask

    // ----------------------------------------------------------------------
    // Chain walk over completed frames before the buffers go back to the pool
    // ----------------------------------------------------------------------
    task automatic check_chains();
        seg_rec_t           r;
        logic [PTR_WID-1:0] addr;
        int                 idle;
        addr = '0;
        idle = 0;
        while (workers_done < CONTEXTS || chk_q.size() != 0) begin
            if (chk_q.size() == 0) begin
                if (idle == TMO) abort_run("Timeout: no completed frame reached the chain check");
                tick();
                idle++;
            end else begin
                r    = chk_q.pop_front();
                idle = 0;
                if (r.exp.sof) addr = r.ptr;
                check_val("chain pointer", 32'(r.ptr), 32'(addr));
                desc_rd_addr = addr;
                tick();
                check_val("desc sof", 32'(r.exp.sof), 32'(desc_rd_data.sof));
                check_val("desc eof", 32'(r.exp.eof), 32'(desc_rd_data.eof));
                check_val("desc size", 32'(r.exp.size), 32'(desc_rd_data.size));
                check_val("desc meta", 32'(r.exp.meta), 32'(desc_rd_data.meta));
                check_val("desc err", 32'(r.exp.err), 32'(desc_rd_data.err));
                if (!desc_rd_data.eof) addr = desc_rd_data.nxt_ptr;
                outstanding[r.ptr] = 1'b0;
                free_vld = 1'b1;
                free_ptr = r.ptr;
                tick();
                free_vld = 1'b0;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int     fd;
        int     col_ctx;
        int     col_segs;
        int     col_last;
        int     col_meta;
        int     col_err;
        string  line;
        frame_t f;

        void'($urandom(42));
        srst         = 1'b1;
        en           = 1'b0;
        free_vld     = 1'b0;
        free_ptr     = '0;
        desc_rd_addr = '0;
        workers_done = 0;
        total_bufs   = 0;
        for (int c = 0; c < CONTEXTS; c++) scatter_req[c] = '0;
        for (int i = 0; i < NUM_BUFFERS; i++) outstanding[i] = 1'b0;

        fd = $fopen("scatter_patterns.txt", "r");
        if (fd == 0) abort_run("Cannot open scatter_patterns.txt");
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                // Comment and blank lines match nothing
                if ($sscanf(line, "%d %d %d %h %d", col_ctx, col_segs, col_last, col_meta,
                            col_err) == 5) begin
                    if (col_ctx < 0 || col_ctx >= CONTEXTS || col_segs < 1
                        || col_segs > MAX_SEGS) begin
                        abort_run($sformatf("Bad line in pattern file: %s", line));
                    end
                    f.ctx     = col_ctx;
                    f.segs    = col_segs;
                    f.last    = col_last;
                    f.meta    = col_meta;
                    f.err_seg = col_err;
                    frames.push_back(f);
                end
            end
        end
        $fclose(fd);
        if (frames.size() < 2) abort_run("Pattern file holds too few frames");

        repeat (3) @(posedge clk);
        #2;
        srst = 1'b0;

        // First frame is posted with the core disabled
        post_frame(frames[0].ctx, frames[0]);
        for (int i = 0; i < 200; i++) begin
            check_val("frame_valid while disabled", 0, 32'(frame_valid));
            tick();
        end
        en = 1'b1;
        finish_frame(frames[0].ctx, frames[0]);

        // Both contexts at once with the chain walk alongside
        fork
            run_context(0);
            run_context(1);
            check_chains();
        join

        check_val("buffers recycled past pool size", 1, 32'(total_bufs > NUM_BUFFERS));
        $display("Done: no errors");
        $finish;
    end

endmodule : tb_scatter

//--- scatter_patterns.txt
# ctx segs last_size meta(hex) err_seg
# err_seg is the index of the bad segment or -1; the first frame runs with the core disabled
0 2 100 a5 -1
0 3 17 01 -1
1 1 64 02 -1
0 1 256 03 0
1 4 200 04 -1
0 5 1 05 2
1 2 255 06 -1
0 3 128 07 -1
1 6 90 08 5
0 4 33 09 -1
1 3 256 0a -1
0 2 77 0b 1
1 5 12 0c -1
0 6 199 0d -1
1 1 5 0e 0
0 3 60 0f -1
1 4 141 10 0
0 2 222 11 -1
1 3 48 12 -1
0 8 256 13 -1
1 7 3 14 3
0 1 9 15 -1
1 2 180 16 -1
0 4 111 17 2
1 3 66 18 -1
0 5 250 19 -1
1 2 31 1a 1
0 3 144 1b -1

//--- scatter.f
buf_desc_pkg.sv
scatter_pkg.sv
fifo_ctxt.sv
arb_rr.sv
buf_free_list.sv
desc_mem.sv
alloc_scatter_core.sv
scatter_top.sv
tb_scatter.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status is the simulation result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_scatter -f scatter.f -o tb_scatter
./obj_dir/tb_scatter
